//--- source/AluUnit.sv
`timescale 1ns/1ps

module AluUnit #(
    parameter int dataWidth = 32
) (
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  cpuPkg::aluOpT        aluOp,
    output logic [dataWidth-1:0] result,
    output logic                 negative,
    output logic                 zero,
    output logic                 carry,
    output logic                 overflow
);

    logic [dataWidth-1:0] addX;
    logic [dataWidth-1:0] addY;
    logic                 addCin;
    logic                 isArith;
    logic [dataWidth-1:0] logicResult;
    logic [dataWidth:0]   sum;

    // Subtraction runs through the adder as x + ~y + 1
    always_comb begin
        addX        = a;
        addY        = b;
        addCin      = 1'b0;
        isArith     = 1'b0;
        logicResult = b;
        case (aluOp)
            cpuPkg::aluAdd, cpuPkg::aluCmn: isArith = 1'b1;
            cpuPkg::aluSub, cpuPkg::aluCmp: begin
                addY    = ~b;
                addCin  = 1'b1;
                isArith = 1'b1;
            end
            cpuPkg::aluRsub: begin
                addX    = b;
                addY    = ~a;
                addCin  = 1'b1;
                isArith = 1'b1;
            end
            cpuPkg::aluAnd, cpuPkg::aluTst: logicResult = a & b;
            cpuPkg::aluOr:                  logicResult = a | b;
            cpuPkg::aluXor, cpuPkg::aluTeq: logicResult = a ^ b;
            cpuPkg::aluMvn:                 logicResult = ~b;
            cpuPkg::aluBic:                 logicResult = a & ~b;
            cpuPkg::aluPassB:               logicResult = b;
            default:                        logicResult = b;
        endcase
    end

    assign sum      = {1'b0, addX} + {1'b0, addY} + {{dataWidth{1'b0}}, addCin};
    assign result   = isArith ? sum[dataWidth-1:0] : logicResult;
    assign negative = result[dataWidth-1];
    assign zero     = (result == '0);
    assign carry    = isArith & sum[dataWidth];   // No-borrow on subtract
    assign overflow = isArith & (addX[dataWidth-1] == addY[dataWidth-1])
                      & (sum[dataWidth-1] != addX[dataWidth-1]);

endmodule

//--- source/BarrelShifter.sv
`timescale 1ns/1ps

module BarrelShifter #(
    parameter int dataWidth = 32
) (
    input  logic [dataWidth-1:0] operand,
    input  logic [4:0]           amount,
    input  cpuPkg::shiftOpT      shiftOp,
    output logic [dataWidth-1:0] result,
    output logic                 carryOut
);

    logic [dataWidth:0]     leftExt;    // Carry on top
    logic [dataWidth:0]     rightExt;   // Carry in bit 0
    logic [dataWidth:0]     arithExt;
    logic [2*dataWidth-1:0] rotExt;
    logic [4:0]             rotAmount;

    assign leftExt   = {1'b0, operand} << amount;
    assign rightExt  = {operand, 1'b0} >> amount;
    assign arithExt  = $signed({operand, 1'b0}) >>> amount;
    assign rotAmount = 5'(amount % dataWidth);
    assign rotExt    = {operand, operand} >> rotAmount;

    always_comb begin
        result   = operand;
        carryOut = 1'b0;
        if (amount != 5'd0) begin
            case (shiftOp)
                cpuPkg::shiftLsl: begin
                    result   = leftExt[dataWidth-1:0];
                    carryOut = leftExt[dataWidth];
                end
                cpuPkg::shiftLsr: begin
                    result   = rightExt[dataWidth:1];
                    carryOut = rightExt[0];
                end
                cpuPkg::shiftAsr: begin
                    result   = arithExt[dataWidth:1];
                    carryOut = arithExt[0];
                end
                cpuPkg::shiftRor: begin
                    result   = rotExt[dataWidth-1:0];
                    carryOut = rotExt[dataWidth-1];   // Last bit wrapped round
                end
                cpuPkg::shiftNone: result = operand;
                default:           result = operand;
            endcase
        end
    end

endmodule

//--- source/ControlCore.sv
`timescale 1ns/1ps

module ControlCore (
    input  cpuPkg::instrIdT  id,
    input  logic             confirmation,
    input  logic             continueButton,
    output cpuPkg::aluOpT    aluOp,
    output cpuPkg::shiftOpT  shiftOp,
    output cpuPkg::rbModeT   rbMode,
    output cpuPkg::flagModeT flagMode,
    output logic             useOffset,
    output logic             enable,
    output logic             isInput,
    output logic             isOutput,
    output logic             haltReq
);

    always_comb begin
        aluOp    = cpuPkg::aluPassB;
        shiftOp  = cpuPkg::shiftNone;
        enable   = 1'b1;
        isInput  = 1'b0;
        isOutput = 1'b0;
        haltReq  = 1'b0;

        case (id)
            7'd1, 7'd14: shiftOp = cpuPkg::shiftLsl;
            7'd2, 7'd15: shiftOp = cpuPkg::shiftAsr;
            7'd3, 7'd16: shiftOp = cpuPkg::shiftLsr;
            7'd19:       shiftOp = cpuPkg::shiftRor;
            7'd4, 7'd6, 7'd10, 7'd23, 7'd28, 7'd29, 7'd30: aluOp = cpuPkg::aluAdd;
            7'd5, 7'd7, 7'd9, 7'd11, 7'd22, 7'd31, 7'd32, 7'd33: aluOp = cpuPkg::aluSub;
            7'd12:       aluOp = cpuPkg::aluAnd;
            7'd13:       aluOp = cpuPkg::aluBic;
            7'd17:       aluOp = cpuPkg::aluRsub;
            7'd18:       aluOp = cpuPkg::aluXor;
            7'd20:       aluOp = cpuPkg::aluTeq;
            7'd21:       aluOp = cpuPkg::aluOr;
            7'd24:       aluOp = cpuPkg::aluCmp;
            7'd25:       aluOp = cpuPkg::aluCmn;
            7'd26:       aluOp = cpuPkg::aluTst;
            7'd34, 7'd65: aluOp = cpuPkg::aluMvn;   // 65 takes the offset
            7'd69: begin   // OUTPUT
                enable   = confirmation;
                isOutput = 1'b1;
            end
            7'd70: begin   // PAUSE
                enable   = continueButton;
                isInput  = 1'b1;
                isOutput = 1'b1;
            end
            7'd71: begin   // INPUT
                enable  = confirmation;
                isInput = 1'b1;
            end
            7'd75: begin   // HALT
                enable  = 1'b0;
                haltReq = 1'b1;
            end
            default: aluOp = cpuPkg::aluPassB;
        endcase

        case (id)
            7'd1, 7'd2, 7'd3, 7'd14, 7'd15, 7'd16, 7'd19: flagMode = cpuPkg::flagShift;
            7'd4, 7'd5, 7'd6, 7'd7, 7'd9, 7'd10, 7'd11, 7'd17, 7'd18, 7'd21,
            7'd22, 7'd23, 7'd31, 7'd32, 7'd33: flagMode = cpuPkg::flagArith;
            7'd8, 7'd12, 7'd13, 7'd20, 7'd24, 7'd25, 7'd26, 7'd27:
                flagMode = cpuPkg::flagCompare;
            7'd34, 7'd65: flagMode = cpuPkg::flagNz;
            default:      flagMode = cpuPkg::flagKeep;
        endcase

        // Compare-like and discard-result forms leave the bank alone
        case (id)
            7'd9, 7'd20, 7'd22, 7'd23, 7'd24, 7'd25, 7'd26, 7'd30, 7'd32, 7'd33:
                rbMode = cpuPkg::rbNone;
            7'd71:   rbMode = cpuPkg::rbInput;
            default: rbMode = (id inside {[7'd1:7'd34], 7'd65}) ? cpuPkg::rbAlu
                                                                : cpuPkg::rbNone;
        endcase

        useOffset = id inside {7'd1, 7'd2, 7'd3, 7'd6, 7'd7, 7'd8, 7'd9, 7'd10, 7'd11, 7'd65};
    end

endmodule

//--- source/ExecuteCore.sv
`timescale 1ns/1ps

module ExecuteCore #(
    parameter int dataWidth = 32,
    parameter int regCount  = 16
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  cpuPkg::instrIdT      id,
    input  cpuPkg::regAddrT      rd,
    input  cpuPkg::regAddrT      rn,
    input  cpuPkg::regAddrT      rm,
    input  logic [15:0]          offset,
    input  logic                 confirmation,
    input  logic                 continueButton,
    input  logic [dataWidth-1:0] inputData,
    output logic [dataWidth-1:0] outputData,
    output logic                 outputStrobe,
    output logic                 waiting,
    output logic                 halted,
    output logic [3:0]           flags
);

    cpuPkg::aluOpT        aluOp;
    cpuPkg::shiftOpT      shiftOp;
    cpuPkg::rbModeT       rbMode;
    cpuPkg::flagModeT     flagMode;
    cpuPkg::runStateT     runState;
    logic                 useOffset, enable, isInput, isOutput, haltReq;
    logic                 commit, outputLoad;
    logic [dataWidth-1:0] operandA, regB, operandB, shiftResult, aluResult, writeData;
    logic                 shiftCarry, aluNegative, aluZero, aluCarry, aluOverflow;

    ControlCore iControlCore (
        .id(id), .confirmation(confirmation), .continueButton(continueButton),
        .aluOp(aluOp), .shiftOp(shiftOp), .rbMode(rbMode), .flagMode(flagMode),
        .useOffset(useOffset), .enable(enable), .isInput(isInput),
        .isOutput(isOutput), .haltReq(haltReq)
    );

    RegisterBank #(.dataWidth(dataWidth), .regCount(regCount)) iRegisterBank (
        .clk(clk), .rstN(rstN), .writeEnable(commit && rbMode != cpuPkg::rbNone),
        .writeAddr(rd), .writeData(writeData), .readAddrA(rn), .readAddrB(rm),
        .readDataA(operandA), .readDataB(regB)
    );

    assign operandB = useOffset ? dataWidth'(offset) : regB;   // Offset zero-extended

    BarrelShifter #(.dataWidth(dataWidth)) iBarrelShifter (
        .operand(operandB), .amount(operandA[4:0]), .shiftOp(shiftOp),
        .result(shiftResult), .carryOut(shiftCarry)
    );

    AluUnit #(.dataWidth(dataWidth)) iAluUnit (
        .a(operandA), .b(shiftResult), .aluOp(aluOp), .result(aluResult),
        .negative(aluNegative), .zero(aluZero), .carry(aluCarry), .overflow(aluOverflow)
    );

    StatusRegister iStatusRegister (
        .clk(clk), .rstN(rstN), .update(commit), .haltReq(haltReq), .flagMode(flagMode),
        .aluNegative(aluNegative), .aluZero(aluZero), .aluCarry(aluCarry),
        .aluOverflow(aluOverflow), .shiftResultNegative(shiftResult[dataWidth-1]),
        .shiftResultZero(shiftResult == '0), .shiftCarry(shiftCarry),
        .flags(flags), .runState(runState)
    );

    always_comb begin
        case (rbMode)
            cpuPkg::rbInput: writeData = inputData;
            cpuPkg::rbAlu:   writeData = aluResult;
            default:         writeData = aluResult;
        endcase
    end

    assign commit     = enable && runState == cpuPkg::sRun;
    assign outputLoad = commit && isOutput && !isInput;   // PAUSE sets both
    assign waiting    = (isInput || isOutput) && !enable;
    assign halted     = (runState == cpuPkg::sHalt);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outputStrobe <= 1'b0;
        end else begin
            outputStrobe <= outputLoad;
        end
    end

    always_ff @(posedge clk) begin
        if (outputLoad) begin
            outputData <= operandA;
        end
    end

endmodule

//--- source/RegisterBank.sv
`timescale 1ns/1ps

module RegisterBank #(
    parameter int dataWidth = 32,
    parameter int regCount  = 16
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 writeEnable,
    input  cpuPkg::regAddrT      writeAddr,
    input  logic [dataWidth-1:0] writeData,
    input  cpuPkg::regAddrT      readAddrA,
    input  cpuPkg::regAddrT      readAddrB,
    output logic [dataWidth-1:0] readDataA,
    output logic [dataWidth-1:0] readDataB
);

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Addresses past a small bank read as zero
    assign readDataA = (readAddrA < regCount) ? regs[readAddrA] : '0;
    assign readDataB = (readAddrB < regCount) ? regs[readAddrB] : '0;

    writeAddrRange: assert property (@(posedge clk) disable iff (!rstN)
        writeEnable |-> writeAddr < regCount);

endmodule

//--- source/StatusRegister.sv
`timescale 1ns/1ps

module StatusRegister (
    input  logic             clk,
    input  logic             rstN,
    input  logic             update,
    input  logic             haltReq,
    input  cpuPkg::flagModeT flagMode,
    input  logic             aluNegative,
    input  logic             aluZero,
    input  logic             aluCarry,
    input  logic             aluOverflow,
    input  logic             shiftResultNegative,
    input  logic             shiftResultZero,
    input  logic             shiftCarry,
    output logic [3:0]       flags,   // N Z C V from bit 3 down
    output cpuPkg::runStateT runState
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            flags <= 4'b0000;
        end else if (update) begin
            case (flagMode)
                cpuPkg::flagShift:
                    flags[3:1] <= {shiftResultNegative, shiftResultZero, shiftCarry};
                cpuPkg::flagArith, cpuPkg::flagCompare:
                    flags <= {aluNegative, aluZero, aluCarry, aluOverflow};
                cpuPkg::flagNz: flags[3:2] <= {aluNegative, aluZero};
                cpuPkg::flagKeep: flags <= flags;
                default:          flags <= flags;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            runState <= cpuPkg::sRun;
        end else if (haltReq && runState == cpuPkg::sRun) begin
            runState <= cpuPkg::sHalt;
        end
    end

    haltFreezesFlags: assert property (@(posedge clk) disable iff (!rstN)
        runState == cpuPkg::sHalt |=> $stable(flags));

endmodule

//--- source/cpuPkg.sv
package cpuPkg;

    typedef logic [6:0] instrIdT;
    typedef logic [3:0] aluOpT;
    typedef logic [3:0] shiftOpT;
    typedef logic [2:0] rbModeT;
    typedef logic [3:0] flagModeT;
    typedef logic [3:0] regAddrT;

    typedef enum logic {sRun, sHalt} runStateT;

    localparam aluOpT aluRsub  = 4'd1;
    localparam aluOpT aluAdd   = 4'd2;
    localparam aluOpT aluAnd   = 4'd3;
    localparam aluOpT aluTst   = 4'd4;
    localparam aluOpT aluSub   = 4'd5;
    localparam aluOpT aluOr    = 4'd6;
    localparam aluOpT aluCmp   = 4'd7;
    localparam aluOpT aluXor   = 4'd8;
    localparam aluOpT aluCmn   = 4'd9;
    localparam aluOpT aluMvn   = 4'd10;
    localparam aluOpT aluPassB = 4'd12;
    localparam aluOpT aluBic   = 4'd13;
    localparam aluOpT aluTeq   = 4'd14;   // Compare-equal

    localparam shiftOpT shiftNone = 4'd0;
    localparam shiftOpT shiftLsr  = 4'd2;
    localparam shiftOpT shiftLsl  = 4'd3;
    localparam shiftOpT shiftAsr  = 4'd4;
    localparam shiftOpT shiftRor  = 4'd5;

    localparam rbModeT rbNone  = 3'd0;
    localparam rbModeT rbAlu   = 3'd1;
    localparam rbModeT rbInput = 3'd2;

    localparam flagModeT flagKeep    = 4'd0;
    localparam flagModeT flagShift   = 4'd1;   // N,Z,C from shifter
    localparam flagModeT flagArith   = 4'd2;
    localparam flagModeT flagCompare = 4'd3;
    localparam flagModeT flagNz      = 4'd4;

endpackage

//--- src.f
source/cpuPkg.sv
source/ControlCore.sv
source/BarrelShifter.sv
source/AluUnit.sv
source/RegisterBank.sv
source/StatusRegister.sv
source/ExecuteCore.sv
testbench/tbExecuteCore.sv

//--- testbench/goldenVectors.txt
# id rd rn rm offset(hex) inputData(hex) hold expect outputData(hex) flags(hex NZCV)
# hold counts cycles with the buttons low; expect 0 flags only, 1 strobe, 2 halted
71 1 0 0 0000 00000010 0 0 00000000 0
71 2 0 0 0000 fffffff0 0 0 00000000 0
6 3 1 0 0025 00000000 0 0 00000000 0
69 0 3 0 0000 00000000 0 1 00000035 0
7 4 1 0 0030 00000000 0 0 00000000 8
69 0 4 0 0000 00000000 0 1 ffffffe0 8
6 5 2 0 0010 00000000 0 0 00000000 6
69 0 5 0 0000 00000000 0 1 00000000 6
71 6 0 0 0000 00000004 0 0 00000000 6
71 7 0 0 0000 9000000f 0 0 00000000 6
14 8 6 7 0000 00000000 0 0 00000000 2
69 0 8 0 0000 00000000 0 1 000000f0 2
16 9 6 7 0000 00000000 0 0 00000000 2
69 0 9 0 0000 00000000 0 1 09000000 2
15 10 6 7 0000 00000000 0 0 00000000 a
69 0 10 0 0000 00000000 0 1 f9000000 a
19 11 6 1 0000 00000000 0 0 00000000 0
69 0 11 0 0000 00000000 0 1 00000001 0
24 1 1 1 0000 00000000 0 0 00000000 6
69 0 1 0 0000 00000000 0 1 00000010 6
9 3 3 0 0036 00000000 0 0 00000000 8
69 0 3 0 0000 00000000 0 1 00000035 8
71 12 0 0 0000 12345678 3 0 00000000 8
69 0 12 0 0000 00000000 2 1 12345678 8
70 0 0 0 0000 00000000 4 0 00000000 8
100 1 2 2 ffff 00000000 0 0 00000000 8
69 0 1 0 0000 00000000 0 1 00000010 8
75 0 0 0 0000 00000000 0 2 00000000 8
69 0 3 0 0000 00000000 0 2 00000000 8
6 1 1 0 0001 00000000 0 2 00000000 8

//--- testbench/tbExecuteCore.sv
`timescale 1ns/1ps

module tbExecuteCore;

    logic            clk;
    logic            rstN;
    cpuPkg::instrIdT id;
    cpuPkg::regAddrT rd;
    cpuPkg::regAddrT rn;
    cpuPkg::regAddrT rm;
    logic [15:0]     offset;
    logic            confirmation;
    logic            continueButton;
    logic [31:0]     inputData;
    logic [31:0]     outputData;
    logic            outputStrobe;
    logic            waiting;
    logic            halted;
    logic [3:0]      flags;

    int errorCount;
    int testCount;
    int failedTests;

    ExecuteCore i_dut (
        .clk(clk), .rstN(rstN), .id(id), .rd(rd), .rn(rn), .rm(rm), .offset(offset),
        .confirmation(confirmation), .continueButton(continueButton),
        .inputData(inputData), .outputData(outputData), .outputStrobe(outputStrobe),
        .waiting(waiting), .halted(halted), .flags(flags)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    // Presents one golden line and checks what it retires
    task automatic runLine(input int lineNo, input int idVal, input int rdVal,
                           input int rnVal, input int rmVal, input logic [15:0] offsetVal,
                           input logic [31:0] dataVal, input int hold, input int expectKind,
                           input logic [31:0] expOut, input logic [3:0] expFlags);
        int startErrors;
        int count;
        int i;
        bit seen;
        bit pauseLine;
        startErrors = errorCount;
        pauseLine   = (idVal == 70);   // PAUSE answers to continue only
        @(posedge clk);
        id             <= 7'(idVal);
        rd             <= 4'(rdVal);
        rn             <= 4'(rnVal);
        rm             <= 4'(rmVal);
        offset         <= offsetVal;
        inputData      <= dataVal;
        confirmation   <= (hold == 0) && !pauseLine;
        continueButton <= (hold == 0) && pauseLine;
        for (i = 0; i < hold; i++) begin
            @(negedge clk);
            if (waiting !== 1'b1)
                reportMismatch("waiting", 32'd1, 32'(waiting));
            if (outputStrobe !== 1'b0)
                reportMismatch("outputStrobe", 32'd0, 32'(outputStrobe));
            @(posedge clk);
        end
        if (pauseLine)
            continueButton <= 1'b1;   // Operator presses
        else
            confirmation <= 1'b1;
        count = 0;
        @(negedge clk);
        while (waiting !== 1'b0 && count < 50) begin
            @(negedge clk);
            count++;
        end
        if (waiting !== 1'b0) begin
            errorCount++;
            $display("Test %0d: instruction still waiting after 50 cycles", lineNo);
        end
        @(posedge clk);   // Retire edge
        id             <= 7'd74;
        confirmation   <= 1'b0;
        continueButton <= 1'b0;
        if (expectKind == 1) begin
            count = 0;
            @(negedge clk);
            while (outputStrobe !== 1'b1 && count < 50) begin
                @(negedge clk);
                count++;
            end
            if (outputStrobe !== 1'b1) begin
                errorCount++;
                $display("Test %0d: no outputStrobe within 50 cycles", lineNo);
            end else if (outputData !== expOut) begin
                reportMismatch("outputData", expOut, outputData);
            end
        end else if (expectKind == 2) begin
            seen = 1'b0;
            for (count = 0; count < 50; count++) begin
                @(negedge clk);
                if (outputStrobe === 1'b1)
                    seen = 1'b1;
            end
            if (seen) begin
                errorCount++;
                $display("Test %0d: outputStrobe pulsed although the core is halted", lineNo);
            end else begin
                $display("Test %0d: halted, no outputStrobe within 50 cycles", lineNo);
            end
        end else begin
            @(negedge clk);
        end
        if (flags !== expFlags)
            reportMismatch("flags", 32'(expFlags), 32'(flags));
        if (halted !== (expectKind == 2))
            reportMismatch("halted", 32'(expectKind == 2), 32'(halted));
        testCount++;
        if (errorCount == startErrors) begin
            $display("Test %0d id %0d: passed", lineNo, idVal);
        end else begin
            failedTests++;
            $display("Test %0d id %0d: failed", lineNo, idVal);
        end
    endtask

    initial begin
        int fd;
        int code;
        int lineNo;
        logic [8*160-1:0] lineBuf;
        int vId, vRd, vRn, vRm, vHold, vExpect;
        logic [15:0] vOffset;
        logic [31:0] vData;
        logic [31:0] vOut;
        logic [3:0]  vFlags;
        rstN           = 1'b0;
        id             = 7'd74;
        rd             = '0;
        rn             = '0;
        rm             = '0;
        offset         = '0;
        confirmation   = 1'b0;
        continueButton = 1'b0;
        inputData      = '0;
        errorCount     = 0;
        testCount      = 0;
        failedTests    = 0;
        lineNo         = 0;
        fd = $fopen("testbench/goldenVectors.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open testbench/goldenVectors.txt");
        end
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        while (fd != 0 && !$feof(fd)) begin
            lineBuf = '0;
            code = $fgets(lineBuf, fd);
            if (code > 0) begin
                code = $sscanf(lineBuf, "%d %d %d %d %h %h %d %d %h %h", vId, vRd, vRn,
                               vRm, vOffset, vData, vHold, vExpect, vOut, vFlags);
                if (code == 10) begin   // Comment lines match nothing
                    lineNo++;
                    runLine(lineNo, vId, vRd, vRn, vRm, vOffset, vData, vHold, vExpect,
                            vOut, vFlags);
                end
            end
        end
        if (fd != 0)
            $fclose(fd);
        $display("%0d tests, %0d passed, %0d failed, %0d errors", testCount,
                 testCount - failedTests, failedTests, errorCount);
        if (errorCount == 0 && testCount > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
